// ==== Makefile ====
TOP = keypadInterfaceTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f keypadInterface.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx 'Everything OK'

clean:
	rm -rf obj_dir

// ==== design/keyDecoder.sv ====
`timescale 1ns/1ns
`include "keypad_consts.svh"

module keyDecoder (
    input  logic [15:0]         Snapshot,
    output logic                SingleKey,
    output keypadPkg::keyClassT KeyClass,
    output logic [3:0]          KeyValue
);

    import keypadPkg::*;

    logic [15:0] pressed;
    logic [3:0]  keyIndex;

    assign pressed   = ~Snapshot;  // rows pull low on a press
    assign SingleKey = $onehot(pressed);

    // position of the pressed key, bit 4c+r
    always_comb begin
        keyIndex = '0;
        for (int i = 0; i < 16; i++) begin
            if (pressed[i]) begin
                keyIndex = 4'(i);
            end
        end
    end

    always_comb begin
        case (keyIndex)
            4'd3, 4'd11, 4'd12, 4'd13, 4'd15: KeyClass = keyOperator;
            4'd14:                            KeyClass = keyEqual;
            default:                          KeyClass = keyDigit;
        endcase
    end

    // column 0: 1 4 7 *, column 1: 2 5 8 0, column 2: 3 6 9 #, column 3: A B C D
    always_comb begin
        case (keyIndex)
            4'd0:    KeyValue = 4'd1;
            4'd1:    KeyValue = 4'd4;
            4'd2:    KeyValue = 4'd7;
            4'd3:    KeyValue = {1'b0, `OP_MUL};   // *
            4'd4:    KeyValue = 4'd2;
            4'd5:    KeyValue = 4'd5;
            4'd6:    KeyValue = 4'd8;
            4'd7:    KeyValue = 4'd0;
            4'd8:    KeyValue = 4'd3;
            4'd9:    KeyValue = 4'd6;
            4'd10:   KeyValue = 4'd9;
            4'd11:   KeyValue = {1'b0, `OP_SIGN};  // # flips the sign
            4'd12:   KeyValue = {1'b0, `OP_ADD};   // A
            4'd13:   KeyValue = {1'b0, `OP_SUB};   // B
            4'd15:   KeyValue = {1'b0, `OP_EXTRA}; // D
            default: KeyValue = 4'd0;              // C is the equal sign
        endcase
    end

endmodule

// ==== design/keyOutputRegister.sv ====
`timescale 1ns/1ns

module keyOutputRegister (
    input  logic                Clock,
    input  logic                Reset,
    input  logic                Load,
    input  keypadPkg::keyClassT KeyClass,
    input  logic [3:0]          KeyValue,
    output logic [3:0]          Number,
    output logic [2:0]          Operator,
    output logic                EqualSign
);

    import keypadPkg::*;

    // each key class touches only its own outputs
    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            Number    <= '0;
            Operator  <= '0;
            EqualSign <= 1'b0;
        end
        else if (Load) begin
            case (KeyClass)
                keyDigit: begin
                    Number    <= KeyValue;
                    EqualSign <= 1'b0;
                end
                keyOperator: begin
                    Operator  <= KeyValue[2:0];
                    EqualSign <= 1'b0;
                end
                keyEqual: begin
                    EqualSign <= 1'b1;  // Number and Operator stay for the result
                end
                default: begin
                    EqualSign <= EqualSign;
                end
            endcase
        end
    end

    loadClassLegal : assert property (
        @(posedge Clock) disable iff (!Reset)
        Load |-> KeyClass inside {keyDigit, keyOperator, keyEqual}
    ) else $error("illegal key class on Load");

endmodule

// ==== design/keypadInterface.sv ====
`timescale 1ns/1ns

module keypadInterface (
    input  logic       Clock,
    input  logic       Reset,
    input  logic [3:0] RowIn,
    output logic [3:0] ColOut,
    output logic       KeyRdy,
    input  logic       KeyRd,
    output logic [3:0] Number,
    output logic [2:0] Operator,
    output logic       EqualSign
);

    import keypadPkg::*;

    logic        tick;
    logic        timerClear;
    logic [15:0] snapshot;
    logic        singleKey;
    keyClassT    keyClass;
    logic [3:0]  keyValue;
    logic        load;

    scanTimer u_scanTimer (
        .Clock (Clock),
        .Reset (Reset),
        .Clear (timerClear),
        .Tick  (tick)
    );

    keypadScanner u_keypadScanner (
        .Clock      (Clock),
        .Reset      (Reset),
        .RowIn      (RowIn),
        .ColOut     (ColOut),
        .Tick       (tick),
        .TimerClear (timerClear),
        .Snapshot   (snapshot),
        .SingleKey  (singleKey),
        .Load       (load),
        .KeyRdy     (KeyRdy),
        .KeyRd      (KeyRd)
    );

    keyDecoder u_keyDecoder (
        .Snapshot  (snapshot),
        .SingleKey (singleKey),
        .KeyClass  (keyClass),
        .KeyValue  (keyValue)
    );

    keyOutputRegister u_keyOutputRegister (
        .Clock     (Clock),
        .Reset     (Reset),
        .Load      (load),
        .KeyClass  (keyClass),
        .KeyValue  (keyValue),
        .Number    (Number),
        .Operator  (Operator),
        .EqualSign (EqualSign)
    );

endmodule

// ==== design/keypadPkg.sv ====
package keypadPkg;

    // what a decoded key means to the consumer
    typedef enum logic [1:0] {
        keyDigit    = 2'b00,  // 0..9, value in KeyValue
        keyOperator = 2'b01,  // op code in KeyValue[2:0]
        keyEqual    = 2'b10   // equal sign, no value
    } keyClassT;

    // scanner FSM states
    // stateScan and stateWaitRelease both walk the columns. Only the first
    // one feeds the debounce check, and the second one just waits for an
    // empty keypad.
    typedef enum logic [1:0] {
        stateScan        = 2'b00,  // collecting a snapshot
        stateCheck       = 2'b01,  // one cycle, debounce compare
        stateWaitRead    = 2'b10,  // KeyRdy high, timer held
        stateWaitRelease = 2'b11   // scanning until no key is seen
    } scanStateT;

endpackage

// ==== design/keypadScanner.sv ====
`timescale 1ns/1ns
`include "keypad_consts.svh"

module keypadScanner (
    input  logic        Clock,
    input  logic        Reset,
    input  logic [3:0]  RowIn,
    output logic [3:0]  ColOut,
    input  logic        Tick,
    output logic        TimerClear,
    output logic [15:0] Snapshot,
    input  logic        SingleKey,
    output logic        Load,
    output logic        KeyRdy,
    input  logic        KeyRd
);

    import keypadPkg::*;

    localparam int CountWidth = $clog2(`KEY_DEBOUNCE_SCANS + 1);

    scanStateT             state;
    logic                  settle;          // first tick of a column seen
    logic [15:0]           prevSnapshot;
    logic [CountWidth-1:0] matchCount;
    logic [CountWidth-1:0] matchCountNext;
    logic                  lastColumn;
    logic                  scanEmpty;

    assign lastColumn = (ColOut == 4'b1110);
    // full scan with the rows of column 0 still on the pins
    assign scanEmpty = &{Snapshot[15:4], RowIn};

    // debounce count for the snapshot just completed
    always_comb begin
        if (!SingleKey) begin
            matchCountNext = '0;
        end
        else if (Snapshot == prevSnapshot) begin
            matchCountNext = matchCount + 1'b1;
        end
        else begin
            matchCountNext = CountWidth'(1);  // new key, first sighting
        end
    end

    // load the output register on the same edge that raises KeyRdy
    assign Load = (state == stateCheck)
               && (matchCountNext == CountWidth'(`KEY_DEBOUNCE_SCANS));

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            state        <= stateScan;
            ColOut       <= `COL_FIRST;
            settle       <= 1'b0;
            Snapshot     <= '1;
            prevSnapshot <= '1;
            matchCount   <= '0;
            KeyRdy       <= 1'b0;
            TimerClear   <= 1'b0;
        end
        else begin
            case (state)
                stateScan, stateWaitRelease: begin
                    if (Tick) begin
                        if (!settle) begin
                            settle <= 1'b1;  // let the rows settle
                        end
                        else begin
                            settle <= 1'b0;
                            for (int c = 0; c < 4; c++) begin
                                if (!ColOut[c]) begin
                                    Snapshot[4*c +: 4] <= RowIn;
                                end
                            end
                            ColOut <= {ColOut[0], ColOut[3:1]};  // next column down
                            if (lastColumn) begin
                                if (state == stateScan) begin
                                    state <= stateCheck;
                                end
                                else if (scanEmpty) begin
                                    state <= stateScan;  // keypad released
                                end
                            end
                        end
                    end
                end
                stateCheck: begin
                    if (Load) begin
                        matchCount   <= '0;
                        prevSnapshot <= '1;
                        KeyRdy       <= 1'b1;
                        TimerClear   <= 1'b1;
                        state        <= stateWaitRead;
                    end
                    else begin
                        matchCount   <= matchCountNext;
                        prevSnapshot <= Snapshot;
                        state        <= stateScan;
                    end
                end
                stateWaitRead: begin
                    if (KeyRd) begin
                        KeyRdy     <= 1'b0;
                        TimerClear <= 1'b0;
                        state      <= stateWaitRelease;
                    end
                end
                default: begin
                    state <= stateScan;
                end
            endcase
        end
    end

    // exactly one column driven low at a time
    colOneLow : assert property (
        @(posedge Clock) disable iff (!Reset)
        $onehot(~ColOut)
    ) else $error("ColOut does not have exactly one low bit");

    // the consumer must strobe KeyRd before KeyRdy may fall
    rdyHeld : assert property (
        @(posedge Clock) disable iff (!Reset)
        KeyRdy && !KeyRd |=> KeyRdy
    ) else $error("KeyRdy dropped without KeyRd");

    // a load closes a complete pass over all four columns
    loadAfterScan : assert property (
        @(posedge Clock) disable iff (!Reset)
        Load |-> ColOut == `COL_FIRST && !settle
    ) else $error("Load without a completed column scan");

endmodule

// ==== design/keypad_consts.svh ====
`ifndef KEYPAD_CONSTS_SVH
`define KEYPAD_CONSTS_SVH

// scan pacing timer
`define SCAN_LFSR_WIDTH 4
`define SCAN_LFSR_SEED 4'b0001
`define SCAN_TICK_PATTERN 4'b1000

// consecutive equal single-key scans before a key is accepted
`define KEY_DEBOUNCE_SCANS 3

// first column of a scan, bit 3 driven low
`define COL_FIRST 4'b0111

// operator codes on the Operator output
`define OP_MUL 3'b100
`define OP_SIGN 3'b001
`define OP_ADD 3'b010
`define OP_SUB 3'b011
`define OP_EXTRA 3'b110

`endif

// ==== design/scanTimer.sv ====
`timescale 1ns/1ns
`include "keypad_consts.svh"

module scanTimer (
    input  logic Clock,
    input  logic Reset,
    input  logic Clear,
    output logic Tick
);

    logic [`SCAN_LFSR_WIDTH-1:0] lfsr;
    logic                        feedback;

    // taps on the top and bottom bits give all 15 nonzero states
    assign feedback = lfsr[`SCAN_LFSR_WIDTH-1] ^ lfsr[0];

    always_ff @(posedge Clock or negedge Reset) begin
        if (!Reset) begin
            lfsr <= `SCAN_LFSR_SEED;
        end
        else if (Clear) begin
            lfsr <= `SCAN_LFSR_SEED;  // parked while the scanner waits
        end
        else begin
            lfsr <= {lfsr[`SCAN_LFSR_WIDTH-2:0], feedback};
        end
    end

    // one cycle per LFSR period
    assign Tick = (lfsr == `SCAN_TICK_PATTERN);

    // the all-zero state would stop the scan for good
    lfsrNeverZero : assert property (
        @(posedge Clock) disable iff (!Reset)
        lfsr != '0
    ) else $error("scan LFSR locked up at zero");

endmodule

// ==== keypadInterface.f ====
+incdir+design
design/keypadPkg.sv
design/scanTimer.sv
design/keypadScanner.sv
design/keyDecoder.sv
design/keyOutputRegister.sv
design/keypadInterface.sv
verification/keypadInterfaceTb.sv

// ==== verification/keypadInterfaceTb.sv ====
`timescale 1ns/1ns
`include "keypad_consts.svh"

module keypadInterfaceTb;

    localparam int ScanCycles    = 8 * 15;               // 8 ticks of 15 cycles
    localparam int EventCycles   = 5 * ScanCycles;       // debounce, read and release
    localparam int TimeoutCycles = 40 * EventCycles + 16000;

    // key at snapshot bit 4c+r
    localparam byte KeyLabel [16] = '{"1", "4", "7", "*", "2", "5", "8", "0",
                                      "3", "6", "9", "#", "A", "B", "C", "D"};

    logic       Clock = 1'b0;
    logic       Reset;
    logic [3:0] RowIn;
    logic [3:0] ColOut;
    logic       KeyRdy;
    logic       KeyRd;
    logic [3:0] Number;
    logic [2:0] Operator;
    logic       EqualSign;

    logic [15:0] pressed;               // keypad model, one flag per key
    int          seed = 32'h291c6659;
    int          pendingKey = -1;       // key the next report should carry
    int          pressCount = 0;        // presses that must be reported
    int          readCount = 0;         // KeyRd strobes issued
    int          rdyCount = 0;          // reports seen
    int          cycleCount = 0;
    logic        rdyPrev = 1'b0;
    logic [3:0]  expNumber = '0;
    logic [2:0]  expOperator = '0;
    logic        expEqual = 1'b0;

    always #2 Clock = ~Clock;

    keypadInterface u_keypadInterface (
        .Clock     (Clock),
        .Reset     (Reset),
        .RowIn     (RowIn),
        .ColOut    (ColOut),
        .KeyRdy    (KeyRdy),
        .KeyRd     (KeyRd),
        .Number    (Number),
        .Operator  (Operator),
        .EqualSign (EqualSign)
    );

    // a pressed key shorts its row to the column driven low
    function automatic logic [3:0] rowLevels(input logic [15:0] keys, input logic [3:0] cols);
        logic [3:0] rows;
        rows = 4'b1111;
        for (int c = 0; c < 4; c++) begin
            if (!cols[c]) begin
                rows = rows & ~keys[4*c +: 4];
            end
        end
        return rows;
    endfunction

    assign RowIn = rowLevels(pressed, ColOut);

    // expected {Number, Operator, EqualSign} after a key
    function automatic logic [7:0] refOutputs(input int key, input logic [3:0] num,
                                              input logic [2:0] op, input logic eq);
        byte label;
        label = KeyLabel[key];
        if (label >= "0" && label <= "9") begin
            num = 4'(label - "0");
            eq  = 1'b0;
        end
        else if (label == "C") begin
            eq = 1'b1;                       // operands stay for the result
        end
        else begin
            eq = 1'b0;
            case (label)
                "*":     op = `OP_MUL;
                "#":     op = `OP_SIGN;
                "A":     op = `OP_ADD;
                "B":     op = `OP_SUB;
                default: op = `OP_EXTRA;     // D
            endcase
        end
        return {num, op, eq};
    endfunction

    function automatic int randomBelow(input int limit);
        return int'($unsigned($random(seed)) % limit);
    endfunction

    function automatic int otherKey(input int avoid);
        int k;
        k = randomBelow(16);
        while (k == avoid) begin
            k = randomBelow(16);
        end
        return k;
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    // compare process, outputs are stable at the falling edge
    always @(negedge Clock) begin
        if (Reset) begin
            assert ($countones(~ColOut) == 1)
                else failRun($sformatf("[ERROR] %0t: ColOut %b has not one low bit",
                                       $time, ColOut));
            if (KeyRdy && !rdyPrev) begin
                assert (pressCount == rdyCount + 1)
                    else failRun("KeyRdy rose although no key press was expected");
                {expNumber, expOperator, expEqual} =
                    refOutputs(pendingKey, expNumber, expOperator, expEqual);
                rdyCount++;
            end
            if (!KeyRdy && rdyPrev) begin
                assert (readCount == rdyCount)
                    else failRun("KeyRdy fell before the consumer strobed KeyRd");
            end
            assert (Number == expNumber && Operator == expOperator && EqualSign == expEqual)
                else failRun($sformatf(
                    "[ERROR] %0t: key %c gave Number %0d Operator %b EqualSign %b, expected %0d %b %b",
                    $time, KeyLabel[pendingKey < 0 ? 0 : pendingKey], Number, Operator,
                    EqualSign, expNumber, expOperator, expEqual));
        end
        rdyPrev = KeyRdy;
    end

    always @(posedge Clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            failRun($sformatf("Timeout: the run did not finish within %0d cycles",
                              TimeoutCycles));
        end
    end

    // counts scans by ColOut coming back to the first column
    task automatic waitScans(input int n);
        logic [3:0] lastCol;
        int         seen;
        seen    = 0;
        lastCol = ColOut;
        while (seen < n) begin
            @(negedge Clock);
            if (ColOut == `COL_FIRST && lastCol != `COL_FIRST) begin
                seen++;
            end
            lastCol = ColOut;
        end
    endtask

    task automatic holdKey(input int key);
        pressed      = '0;
        pressed[key] = 1'b1;
        pendingKey   = key;
        pressCount++;
    endtask

    // consumer side, read after a random delay
    task automatic readKey();
        int delay;
        while (!KeyRdy) begin
            @(negedge Clock);
        end
        delay = randomBelow(64);
        repeat (delay) @(negedge Clock);
        KeyRd = 1'b1;
        readCount++;
        @(negedge Clock);
        KeyRd = 1'b0;
    endtask

    task automatic pressAndRead(input int key);
        holdKey(key);
        readKey();
        pressed = '0;
        waitScans(2);                        // empty scan releases the scanner
    endtask

    initial begin
        int order [16];
        int j;
        int tmp;
        int key;
        int other;
        Reset   = 1'b0;
        KeyRd   = 1'b0;
        pressed = '0;
        repeat (3) @(negedge Clock);
        Reset = 1'b1;
        @(negedge Clock);

        assert (!KeyRdy && Number == 4'd0 && Operator == 3'd0 && !EqualSign
                && $countones(~ColOut) == 1)
            else failRun($sformatf(
                "[ERROR] %0t: after reset KeyRdy %b Number %0d Operator %b EqualSign %b ColOut %b",
                $time, KeyRdy, Number, Operator, EqualSign, ColOut));

        for (int i = 0; i < 16; i++) begin
            pressAndRead(i);                 // table order
        end

        for (int i = 0; i < 16; i++) begin
            order[i] = i;
        end
        for (int i = 15; i > 0; i--) begin
            j        = randomBelow(i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 16; i++) begin
            pressAndRead(order[i]);
        end

        // two keys at once
        key            = randomBelow(16);
        other          = otherKey(key);
        pressed        = '0;
        pressed[key]   = 1'b1;
        pressed[other] = 1'b1;
        waitScans(10);
        assert (!KeyRdy && rdyCount == pressCount)
            else failRun("two keys held together were reported as a key press");
        pressed = '0;
        waitScans(2);

        // key held on through the read
        key = randomBelow(16);
        holdKey(key);
        readKey();
        waitScans(5);
        assert (!KeyRdy && rdyCount == pressCount)
            else failRun("a key still held after its read was reported again");
        pressed = '0;
        waitScans(2);
        pressAndRead(key);

        // new key at every scan boundary
        waitScans(1);
        key = randomBelow(16);
        for (int i = 0; i < 8; i++) begin
            key          = otherKey(key);
            pressed      = '0;
            pressed[key] = 1'b1;
            waitScans(1);
        end
        assert (!KeyRdy && rdyCount == pressCount)
            else failRun("a key that changed every scan was accepted");
        pressAndRead(otherKey(key));

        $display("Everything OK");
        $finish;
    end

endmodule
